/* hdl/leaf_pkg.sv */
package leaf_pkg;

    localparam int PAYLOAD_W = 32;
    localparam int LEAF_W = 5;
    localparam int PORT_W = 4;
    localparam int ADDR_W = 7;
    localparam int OUT_IDX_W = 3;

    // Stream counts of the i4o5 leaf shape
    localparam int NUM_IN_PORTS = 4;
    localparam int NUM_OUT_PORTS = 5;

    localparam logic [LEAF_W-1:0] LEAF_ID = 5'd3;
    localparam logic [PORT_W-1:0] CFG_PORT = 4'd0;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [PAYLOAD_W-1:0] payload_t;
    typedef logic [LEAF_W-1:0] leaf_id_t;
    typedef logic [PORT_W-1:0] port_id_t;
    typedef logic [ADDR_W-1:0] seq_t;
    typedef logic [OUT_IDX_W-1:0] out_idx_t;

    // Tree packet, 49 bits with valid in the top bit
    typedef struct packed {
        logic     valid;
        leaf_id_t dest_leaf;
        port_id_t dest_port;
        seq_t     addr;
        payload_t payload;
    } bft_packet_t;

    // One routing table entry per kernel output
    typedef struct packed {
        logic     enable;
        leaf_id_t dest_leaf;
        port_id_t dest_port;
    } route_t;

    // Lies over the low payload bits of a configuration packet
    typedef struct packed {
        out_idx_t out_index;
        logic     enable;
        leaf_id_t dest_leaf;
        port_id_t dest_port;
    } route_cfg_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SEND,
        ARB_HOLD
    } arb_state_t;

endpackage

/* hdl/leaf_ingress.sv */
module leaf_ingress (
    input  logic                                               clk,
    input  logic                                               rst,
    input  leaf_pkg::bft_packet_t                              din_bft,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]                  to_user_ack,
    output leaf_pkg::payload_t [leaf_pkg::NUM_IN_PORTS-1:0]    to_user_data,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]                  to_user_vld,
    output logic                                               cfg_wr,
    output leaf_pkg::route_cfg_t                               cfg
);

    logic for_us;

    assign for_us = din_bft.valid && (din_bft.dest_leaf == leaf_pkg::LEAF_ID);

    // Configuration takes effect at the edge that ends the packet cycle
    assign cfg_wr = for_us && (din_bft.dest_port == leaf_pkg::CFG_PORT);
    assign cfg = din_bft.payload[$bits(leaf_pkg::route_cfg_t)-1:0];

    // One circular queue per kernel input, port p+1 lands in queue p.
    // Ports above NUM_IN_PORTS match no queue and are dropped
    for (genvar p = 0; p < leaf_pkg::NUM_IN_PORTS; p++) begin : g_queue
        leaf_pkg::payload_t mem [leaf_pkg::QUEUE_DEPTH];
        logic [leaf_pkg::QUEUE_PTR_W:0] wr_ptr;
        logic [leaf_pkg::QUEUE_PTR_W:0] rd_ptr;
        logic wr_en;
        logic rd_en;
        logic empty;
        logic full;

        // The extra pointer bit tells a full queue from an empty one
        assign empty = (wr_ptr == rd_ptr);
        assign full = (wr_ptr[leaf_pkg::QUEUE_PTR_W] != rd_ptr[leaf_pkg::QUEUE_PTR_W])
                   && (wr_ptr[leaf_pkg::QUEUE_PTR_W-1:0] == rd_ptr[leaf_pkg::QUEUE_PTR_W-1:0]);

        assign wr_en = for_us
                    && (din_bft.dest_port == leaf_pkg::port_id_t'(p + 1))
                    && !full;
        assign rd_en = to_user_vld[p] && to_user_ack[p];

        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[wr_ptr[leaf_pkg::QUEUE_PTR_W-1:0]] <= din_bft.payload;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (rd_en) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end

        // Head of the queue is offered until the kernel acks it
        assign to_user_vld[p] = !empty;
        assign to_user_data[p] = mem[rd_ptr[leaf_pkg::QUEUE_PTR_W-1:0]];
    end

endmodule

/* hdl/leaf_egress.sv */
module leaf_egress (
    input  logic                                               clk,
    input  logic                                               rst,
    input  leaf_pkg::payload_t [leaf_pkg::NUM_OUT_PORTS-1:0]   from_user_data,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]                 from_user_vld,
    input  leaf_pkg::route_t [leaf_pkg::NUM_OUT_PORTS-1:0]     routes,
    input  logic                                               resend,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                 from_user_ack,
    output leaf_pkg::bft_packet_t                              pkt_out
);

    leaf_pkg::arb_state_t state;
    leaf_pkg::arb_state_t state_nxt;
    leaf_pkg::out_idx_t rr_ptr;
    leaf_pkg::out_idx_t grant_idx;
    logic grant_vld;
    logic grant;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] req;
    leaf_pkg::seq_t seq_cnt [leaf_pkg::NUM_OUT_PORTS];
    leaf_pkg::bft_packet_t pkt_reg;

    // Only routed outputs compete, an unrouted one just keeps waiting
    always_comb begin
        for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
            req[i] = from_user_vld[i] && routes[i].enable;
        end
    end

    // Search starts at the round-robin pointer and wraps
    always_comb begin
        int cand;
        grant_vld = 1'b0;
        grant_idx = '0;
        for (int k = 0; k < leaf_pkg::NUM_OUT_PORTS; k++) begin
            cand = int'(rr_ptr) + k;
            if (cand >= leaf_pkg::NUM_OUT_PORTS) begin
                cand = cand - leaf_pkg::NUM_OUT_PORTS;
            end
            if (!grant_vld && req[cand]) begin
                grant_vld = 1'b1;
                grant_idx = leaf_pkg::out_idx_t'(cand);
            end
        end
    end

    assign grant = grant_vld && !resend;

    always_comb begin
        for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
            from_user_ack[i] = grant && (grant_idx == leaf_pkg::out_idx_t'(i));
        end
    end

    // A packet shown while resend masks the link is kept in ARB_HOLD
    always_comb begin
        case (state)
            leaf_pkg::ARB_SEND, leaf_pkg::ARB_HOLD: begin
                if (resend) begin
                    state_nxt = leaf_pkg::ARB_HOLD;
                end else begin
                    state_nxt = grant ? leaf_pkg::ARB_SEND : leaf_pkg::ARB_IDLE;
                end
            end
            default: begin
                state_nxt = grant ? leaf_pkg::ARB_SEND : leaf_pkg::ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= leaf_pkg::ARB_IDLE;
            rr_ptr <= '0;
            for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
                seq_cnt[i] <= '0;
            end
        end else begin
            state <= state_nxt;
            if (grant) begin
                rr_ptr <= (grant_idx == leaf_pkg::NUM_OUT_PORTS - 1) ? '0 : grant_idx + 1'b1;
                seq_cnt[grant_idx] <= seq_cnt[grant_idx] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            pkt_reg.valid <= 1'b1;
            pkt_reg.dest_leaf <= routes[grant_idx].dest_leaf;
            pkt_reg.dest_port <= routes[grant_idx].dest_port;
            pkt_reg.addr <= seq_cnt[grant_idx];
            pkt_reg.payload <= from_user_data[grant_idx];
        end
    end

    assign pkt_out = (state == leaf_pkg::ARB_IDLE) ? '0 : pkt_reg;

endmodule

/* hdl/leaf_interface.sv */
module leaf_interface (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               ap_start,
    input  logic                                               resend,
    input  leaf_pkg::bft_packet_t                              din_bft,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]                  to_user_ack,
    input  leaf_pkg::payload_t [leaf_pkg::NUM_OUT_PORTS-1:0]   from_user_data,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]                 from_user_vld,
    output leaf_pkg::bft_packet_t                              dout_bft,
    output leaf_pkg::payload_t [leaf_pkg::NUM_IN_PORTS-1:0]    to_user_data,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]                  to_user_vld,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                 from_user_ack,
    output logic                                               user_rst
);

    logic cfg_wr;
    leaf_pkg::route_cfg_t cfg;
    leaf_pkg::route_t [leaf_pkg::NUM_OUT_PORTS-1:0] route_tbl;
    leaf_pkg::bft_packet_t egress_pkt;
    logic started;

    leaf_ingress leaf_ingress_inst (
        .clk          (clk),
        .rst          (rst),
        .din_bft      (din_bft),
        .to_user_ack  (to_user_ack),
        .to_user_data (to_user_data),
        .to_user_vld  (to_user_vld),
        .cfg_wr       (cfg_wr),
        .cfg          (cfg)
    );

    leaf_egress leaf_egress_inst (
        .clk            (clk),
        .rst            (rst),
        .from_user_data (from_user_data),
        .from_user_vld  (from_user_vld),
        .routes         (route_tbl),
        .resend         (resend),
        .from_user_ack  (from_user_ack),
        .pkt_out        (egress_pkt)
    );

    // Output index 1 maps to table entry 0, indices 0, 6 and 7 are ignored
    always_ff @(posedge clk) begin
        if (rst) begin
            route_tbl <= '0;
        end else if (cfg_wr && (cfg.out_index != '0)
                     && (cfg.out_index <= leaf_pkg::NUM_OUT_PORTS)) begin
            route_tbl[cfg.out_index - 1'b1].enable <= cfg.enable;
            route_tbl[cfg.out_index - 1'b1].dest_leaf <= cfg.dest_leaf;
            route_tbl[cfg.out_index - 1'b1].dest_port <= cfg.dest_port;
        end
    end

    // Kernel leaves reset once ap_start has been seen
    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    assign user_rst = !started;

    assign dout_bft = resend ? '0 : egress_pkt;

endmodule

/* hdl/user_kernel.sv */
module user_kernel (
    input  logic                                               clk,
    input  logic                                               rst,
    input  leaf_pkg::payload_t [leaf_pkg::NUM_IN_PORTS-1:0]    in_data,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]                  in_vld,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]                 out_ack,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]                  in_ack,
    output leaf_pkg::payload_t [leaf_pkg::NUM_OUT_PORTS-1:0]   out_data,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                 out_vld
);

    logic running;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] full;

    // Keeps in_ack low while the kernel sits in reset
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // Input 1 feeds two registers and needs both of them free
    always_comb begin
        for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
            in_ack[i] = running && in_vld[i] && !full[i];
        end
        in_ack[0] = in_ack[0] && !full[leaf_pkg::NUM_OUT_PORTS-1];
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
            if (in_ack[i]) begin
                out_data[i] <= in_data[i] + 1'b1;
            end
        end
        if (in_ack[0]) begin
            out_data[leaf_pkg::NUM_OUT_PORTS-1] <= ~in_data[0];
        end
    end

    // A register never loads and drains in one cycle since in_ack needs it empty
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= '0;
        end else begin
            for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
                if (in_ack[i]) begin
                    full[i] <= 1'b1;
                end else if (out_ack[i]) begin
                    full[i] <= 1'b0;
                end
            end
            if (in_ack[0]) begin
                full[leaf_pkg::NUM_OUT_PORTS-1] <= 1'b1;
            end else if (out_ack[leaf_pkg::NUM_OUT_PORTS-1]) begin
                full[leaf_pkg::NUM_OUT_PORTS-1] <= 1'b0;
            end
        end
    end

    assign out_vld = full;

endmodule

/* hdl/leaf_i4o5.sv */
module leaf_i4o5 (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ap_start,
    input  logic                  resend,
    input  leaf_pkg::bft_packet_t din_bft,
    output leaf_pkg::bft_packet_t dout_bft
);

    leaf_pkg::payload_t [leaf_pkg::NUM_IN_PORTS-1:0] to_user_data;
    logic [leaf_pkg::NUM_IN_PORTS-1:0] to_user_vld;
    logic [leaf_pkg::NUM_IN_PORTS-1:0] to_user_ack;
    leaf_pkg::payload_t [leaf_pkg::NUM_OUT_PORTS-1:0] from_user_data;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] from_user_vld;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] from_user_ack;
    logic user_rst;

    leaf_interface leaf_interface_inst (
        .clk            (clk),
        .rst            (rst),
        .ap_start       (ap_start),
        .resend         (resend),
        .din_bft        (din_bft),
        .to_user_ack    (to_user_ack),
        .from_user_data (from_user_data),
        .from_user_vld  (from_user_vld),
        .dout_bft       (dout_bft),
        .to_user_data   (to_user_data),
        .to_user_vld    (to_user_vld),
        .from_user_ack  (from_user_ack),
        .user_rst       (user_rst)
    );

    user_kernel user_kernel_inst (
        .clk      (clk),
        .rst      (user_rst),
        .in_data  (to_user_data),
        .in_vld   (to_user_vld),
        .out_ack  (from_user_ack),
        .in_ack   (to_user_ack),
        .out_data (from_user_data),
        .out_vld  (from_user_vld)
    );

endmodule

/* tests/leaf_asserts.sv */
module leaf_asserts (
    input logic                                             clk,
    input logic                                             rst,
    input logic                                             resend,
    input leaf_pkg::bft_packet_t                            din_bft,
    input leaf_pkg::bft_packet_t                            dout_bft,
    input leaf_pkg::payload_t [leaf_pkg::NUM_IN_PORTS-1:0]  to_user_data,
    input logic [leaf_pkg::NUM_IN_PORTS-1:0]                to_user_vld,
    input logic [leaf_pkg::NUM_IN_PORTS-1:0]                to_user_ack,
    input logic [leaf_pkg::NUM_OUT_PORTS-1:0]               from_user_vld,
    input logic [leaf_pkg::NUM_OUT_PORTS-1:0]               from_user_ack,
    input logic                                             user_rst
);

    // A chosen word shows up on the link one cycle later unless resend masks it
    ack_reaches_link: assert property (@(posedge clk) disable iff (rst)
        (|from_user_ack) |=> (resend || dout_bft.valid))
        else $error("acked kernel word did not reach dout_bft in the next cycle");

    one_ack_per_cycle: assert property (@(posedge clk) disable iff (rst)
        $onehot0(from_user_ack))
        else $error("more than one kernel output acked in one cycle");

    ack_needs_valid: assert property (@(posedge clk) disable iff (rst)
        (from_user_ack & ~from_user_vld) == '0)
        else $error("kernel output acked without a valid word");

    kernel_quiet_in_reset: assert property (@(posedge clk) disable iff (rst)
        user_rst |-> ((to_user_ack == '0) && (from_user_vld == '0)))
        else $error("kernel answered while held in reset");

    // Queue level is tracked from the stream traffic alone
    for (genvar p = 0; p < leaf_pkg::NUM_IN_PORTS; p++) begin : g_port
        logic [leaf_pkg::QUEUE_PTR_W:0] level;
        logic wr;
        logic rd;

        assign wr = din_bft.valid && (din_bft.dest_leaf == leaf_pkg::LEAF_ID)
                 && (din_bft.dest_port == leaf_pkg::port_id_t'(p + 1));
        assign rd = to_user_vld[p] && to_user_ack[p];

        always_ff @(posedge clk) begin
            if (rst) begin
                level <= '0;
            end else if (wr && !rd) begin
                level <= level + 1'b1;
            end else if (rd && !wr) begin
                level <= level - 1'b1;
            end
        end

        no_overfill: assert property (@(posedge clk) disable iff (rst)
            wr |-> (level != (leaf_pkg::QUEUE_PTR_W + 1)'(leaf_pkg::QUEUE_DEPTH)))
            else $error("queue %0d written while full", p + 1);

        head_stable: assert property (@(posedge clk) disable iff (rst)
            (to_user_vld[p] && !to_user_ack[p]) |=> $stable(to_user_data[p]))
            else $error("to_user_data %0d changed before its ack", p + 1);
    end

endmodule

/* tests/leaf_tb.sv */
module leaf_tb;

    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int RESULT_WAIT = 200;

    logic clk;
    logic rst;
    logic ap_start;
    logic resend;
    leaf_pkg::bft_packet_t din_bft;
    leaf_pkg::bft_packet_t dout_bft;

    integer seed = 92661;
    int error_count = 0;
    int check_count = 0;
    leaf_pkg::bft_packet_t exp_q [$];
    leaf_pkg::bft_packet_t rx_q [$];
    leaf_pkg::leaf_id_t route_leaf [1:5];
    leaf_pkg::port_id_t route_port [1:5];
    leaf_pkg::seq_t seq_model [1:5];

    leaf_i4o5 leaf_i4o5_inst (
        .clk      (clk),
        .rst      (rst),
        .ap_start (ap_start),
        .resend   (resend),
        .din_bft  (din_bft),
        .dout_bft (dout_bft)
    );

    bind leaf_interface leaf_asserts leaf_asserts_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_packet(input leaf_pkg::bft_packet_t got,
                                input leaf_pkg::bft_packet_t exp, input string name);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_payload(input leaf_pkg::payload_t got,
                                 input leaf_pkg::payload_t exp, input string name);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic leaf_pkg::payload_t cfg_word(input int out_idx, input logic en,
                                                    input leaf_pkg::leaf_id_t leaf,
                                                    input leaf_pkg::port_id_t port);
        leaf_pkg::route_cfg_t cfg;
        leaf_pkg::payload_t word;
        cfg = {leaf_pkg::out_idx_t'(out_idx), en, leaf, port};
        word = '0;
        word[$bits(leaf_pkg::route_cfg_t)-1:0] = cfg;
        return word;
    endfunction

    // One packet per call, held on the link for a single cycle
    task automatic drive_packet(input leaf_pkg::leaf_id_t leaf, input leaf_pkg::port_id_t port,
                                input leaf_pkg::payload_t data);
        @(posedge clk);
        #1;
        din_bft = {1'b1, leaf, port, leaf_pkg::seq_t'(0), data};
        @(posedge clk);
        #1;
        din_bft = '0;
    endtask

    task automatic config_route(input int out_idx, input logic en,
                                input leaf_pkg::leaf_id_t leaf, input leaf_pkg::port_id_t port);
        drive_packet(leaf_pkg::LEAF_ID, leaf_pkg::CFG_PORT, cfg_word(out_idx, en, leaf, port));
        route_leaf[out_idx] = leaf;
        route_port[out_idx] = port;
    endtask

    task automatic predict_output(input int out_idx, input leaf_pkg::payload_t data);
        leaf_pkg::bft_packet_t pkt;
        pkt = {1'b1, route_leaf[out_idx], route_port[out_idx], seq_model[out_idx], data};
        exp_q.push_back(pkt);
        seq_model[out_idx] = seq_model[out_idx] + 1'b1;
    endtask

    // Output i carries input i plus one and output 5 the inverse of input 1
    task automatic predict_word(input int port, input leaf_pkg::payload_t data);
        predict_output(port, data + 32'd1);
        if (port == 1) begin
            predict_output(leaf_pkg::NUM_OUT_PORTS, ~data);
        end
    endtask

    task automatic send_word(input int port, input leaf_pkg::payload_t data);
        drive_packet(leaf_pkg::LEAF_ID, leaf_pkg::port_id_t'(port), data);
        predict_word(port, data);
    endtask

    task automatic expect_silence(input int cycles, input string what);
        repeat (cycles) @(posedge clk);
        if (rx_q.size() != 0) begin
            error_count++;
            $display("Error at %0t: %0d packets left the leaf %s", $time, rx_q.size(), what);
            rx_q.delete();
        end
    endtask

    // Outputs interleave by arbitration, so packets are matched per destination in order
    task automatic compare_results();
        leaf_pkg::bft_packet_t exp;
        leaf_pkg::bft_packet_t got;
        int waited;
        int found;
        waited = 0;
        while (rx_q.size() < exp_q.size() && waited < RESULT_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (rx_q.size() < exp_q.size()) begin
            error_count++;
            $display("Error at %0t: timed out waiting for dout_bft.valid, %0d of %0d seen",
                     $time, rx_q.size(), exp_q.size());
        end
        repeat (10) @(posedge clk);
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            found = -1;
            foreach (rx_q[i]) begin
                if (found < 0 && rx_q[i].dest_leaf == exp.dest_leaf
                    && rx_q[i].dest_port == exp.dest_port) begin
                    found = i;
                end
            end
            if (found < 0) begin
                error_count++;
                $display("Error at %0t: no packet arrived for leaf %0d port %0d addr %0d",
                         $time, exp.dest_leaf, exp.dest_port, exp.addr);
            end else begin
                got = rx_q[found];
                rx_q.delete(found);
                check_payload(got.payload, exp.payload, "dout_bft.payload");
                got.payload = '0;
                exp.payload = '0;
                check_packet(got, exp, "dout_bft header");
            end
        end
        expect_silence(0, "beyond the expected ones");
    endtask

    task automatic before_start_gating();
        for (int i = 1; i <= 5; i++) begin
            config_route(i, 1'b1, leaf_pkg::leaf_id_t'(8 + i), leaf_pkg::port_id_t'(2 + i));
        end
        send_word(1, $random(seed));
        send_word(3, $random(seed));
        send_word(4, $random(seed));
        expect_silence(30, "while the kernel waits for ap_start");
        @(posedge clk);
        #1;
        ap_start = 1'b1;
        @(posedge clk);
        #1;
        ap_start = 1'b0;
        compare_results();
    endtask

    // Output 2 has sent nothing yet so its addr runs 0, 1, 2
    task automatic sequence_numbering();
        repeat (3) send_word(2, $random(seed));
        compare_results();
    endtask

    task automatic routing_and_data();
        for (int i = 1; i <= 5; i++) begin
            config_route(i, 1'b1, leaf_pkg::leaf_id_t'(16 + i), leaf_pkg::port_id_t'(9 + i));
        end
        repeat (2) begin
            for (int p = 1; p <= 4; p++) begin
                send_word(p, $random(seed));
            end
        end
        compare_results();
    endtask

    task automatic packet_filtering();
        drive_packet(5'd4, 4'd1, $random(seed));
        drive_packet(leaf_pkg::LEAF_ID, 4'd5, $random(seed));
        drive_packet(leaf_pkg::LEAF_ID, 4'd15, $random(seed));
        // Would switch output 1 off if another leaf's configuration got through
        drive_packet(5'd7, leaf_pkg::CFG_PORT, cfg_word(1, 1'b0, 5'd0, 4'd0));
        expect_silence(30, "for packets that should be dropped");
        send_word(1, $random(seed));
        compare_results();
    endtask

    task automatic resend_stall();
        fork
            repeat (2) begin
                for (int p = 1; p <= 4; p++) begin
                    send_word(p, $random(seed));
                end
            end
            begin
                repeat (8) @(posedge clk);
                #1;
                resend = 1'b1;
                repeat (12) @(posedge clk);
                #1;
                resend = 1'b0;
            end
        join
        compare_results();
    endtask

    task automatic unrouted_output();
        leaf_pkg::payload_t data;
        data = $random(seed);
        config_route(3, 1'b0, route_leaf[3], route_port[3]);
        drive_packet(leaf_pkg::LEAF_ID, 4'd3, data);
        expect_silence(40, "from a disabled output");
        config_route(3, 1'b1, 5'd20, 4'd9);
        predict_word(3, data);
        compare_results();
    endtask

    // The link is settled at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && resend) begin
                check_packet(dout_bft, '0, "dout_bft during resend");
            end
            if (!rst && dout_bft.valid) begin
                rx_q.push_back(dout_bft);
            end
        end
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Finished with %0d errors in %0d checks", error_count, check_count);
        $display("test failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        ap_start = 1'b0;
        resend = 1'b0;
        din_bft = '0;
        for (int i = 1; i <= 5; i++) begin
            seq_model[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        before_start_gating();
        sequence_numbering();
        routing_and_data();
        packet_filtering();
        resend_stall();
        unrouted_output();
        $display("Finished with %0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
hdl/leaf_pkg.sv
hdl/leaf_ingress.sv
hdl/leaf_egress.sv
hdl/leaf_interface.sv
hdl/user_kernel.sv
hdl/leaf_i4o5.sv
tests/leaf_asserts.sv
tests/leaf_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module leaf_tb -f tb.f

run: compile
	@out=$$(./obj_dir/Vleaf_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
